// File: sources.f
hdl/circle_pkg.sv
hdl/fillscreen.sv
hdl/circle_regs.sv
hdl/circle_ctrl.sv
hdl/circle_datapath.sv
hdl/circle_top.sv
tb/circle_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module circle_tb -o circle_sim

sim_out=$(./obj_dir/circle_sim 2>&1) || true
printf '%s\n' "$sim_out"

if grep -qx "TEST PASSED" <<< "$sim_out"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// File: tb/circle_tb.sv
`timescale 1ns/100ps

module circle_tb;

    localparam int pix_w      = circle_pkg::x_dw + circle_pkg::y_dw + circle_pkg::colour_dw;
    localparam int fill_cmd   = 1 << circle_pkg::cmd_fill_bit;
    localparam int circle_cmd = 1 << circle_pkg::cmd_circle_bit;

    logic                             clk;
    logic                             resetn;
    logic                             wb_cyc;
    logic                             wb_stb;
    logic                             wb_we;
    logic [circle_pkg::wb_aw-1:0]     wb_adr;
    logic [circle_pkg::wb_dw-1:0]     wb_dat_w;
    logic [circle_pkg::wb_dw-1:0]     wb_dat_r;
    logic                             wb_ack;
    logic [circle_pkg::x_dw-1:0]      vga_x;
    logic [circle_pkg::y_dw-1:0]      vga_y;
    logic [circle_pkg::colour_dw-1:0] vga_colour;
    logic                             vga_plot;

    // One row per operation
    string            row_name[$];
    int               row_cmd[$];
    int               row_radius[$];
    int               row_cx[$];
    int               row_cy[$];
    int               row_colour[$];
    logic [pix_w-1:0] got_q[$];
    logic [pix_w-1:0] exp_q[$];
    logic [31:0]      rng;
    int               cycles = 0;
    int               cycle_limit = 2000;

    circle_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Pixel stream capture away from the driving edge
    always @(negedge clk) begin
        if (resetn && vga_plot) begin
            got_q.push_back({vga_x, vga_y, vga_colour});
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            abort_run($sformatf("Run timed out after %0d cycles without finishing", cycles));
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [circle_pkg::wb_dw-1:0] exp_w,
                              input logic [circle_pkg::wb_dw-1:0] act_w);
        if (act_w !== exp_w) begin
            abort_run($sformatf("Fail %s expected 0x%08h actual 0x%08h", name, exp_w, act_w));
        end
    endtask

    task automatic check_count(input string name, input int exp_n, input int act_n);
        if (act_n != exp_n) begin
            abort_run($sformatf("Fail %s pixel count expected %0d actual %0d",
                                name, exp_n, act_n));
        end
    endtask

    task automatic check_pixel(input string name, input int idx,
                               input logic [circle_pkg::x_dw-1:0] exp_x,
                               input logic [circle_pkg::y_dw-1:0] exp_y,
                               input logic [circle_pkg::colour_dw-1:0] exp_c,
                               input logic [circle_pkg::x_dw-1:0] act_x,
                               input logic [circle_pkg::y_dw-1:0] act_y,
                               input logic [circle_pkg::colour_dw-1:0] act_c);
        if ({act_x, act_y, act_c} !== {exp_x, exp_y, exp_c}) begin
            abort_run($sformatf(
                "Fail %s pixel %0d expected (%0d,%0d) colour %0d actual (%0d,%0d) colour %0d",
                name, idx, exp_x, exp_y, exp_c, act_x, act_y, act_c));
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] s;
        s = state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Wishbone classic cycle held until ack
    task automatic bus_cycle(input logic we, input logic [circle_pkg::wb_aw-1:0] adr,
                             input logic [circle_pkg::wb_dw-1:0] wdata,
                             output logic [circle_pkg::wb_dw-1:0] rdata);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        do begin
            @(posedge clk);
        end while (wb_ack !== 1'b1);
        rdata = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic add_row(input string name, input int cmd, input int r, input int cx,
                           input int cy, input int col);
        row_name.push_back(name);
        row_cmd.push_back(cmd);
        row_radius.push_back(r);
        row_cx.push_back(cx);
        row_cy.push_back(cy);
        row_colour.push_back(col);
        if (cmd == fill_cmd) begin
            cycle_limit = cycle_limit + circle_pkg::screen_w * circle_pkg::screen_h;
        end else begin
            cycle_limit = cycle_limit + 9 * (r + 2);
        end
    endtask

    // Midpoint reference with eight octant candidates per step
    task automatic model_circle(input int r, input int cx, input int cy, input int col);
        int ox, oy, crit, dx, dy, px, py;
        bit swap;
        ox   = r;
        oy   = 0;
        crit = 1 - r;
        while (oy <= ox) begin
            for (int sel = 0; sel < 8; sel++) begin
                // Octants 1, 2, 5 and 6 trade the two offsets
                swap = (sel == 1) || (sel == 2) || (sel == 5) || (sel == 6);
                dx   = swap ? oy : ox;
                dy   = swap ? ox : oy;
                px   = (sel <= 1 || sel >= 6) ? cx + dx : cx - dx;
                py   = (sel <= 3) ? cy + dy : cy - dy;
                if (px >= 0 && px < circle_pkg::screen_w
                    && py >= 0 && py < circle_pkg::screen_h) begin
                    exp_q.push_back({circle_pkg::x_dw'(px), circle_pkg::y_dw'(py),
                                     circle_pkg::colour_dw'(col)});
                end
            end
            oy = oy + 1;
            if (crit <= 0) begin
                crit = crit + 2 * oy + 1;
            end else begin
                ox   = ox - 1;
                crit = crit + 2 * (oy - ox) + 1;
            end
        end
    endtask

    task automatic run_row(input int i);
        logic [circle_pkg::wb_dw-1:0] rd;
        logic [circle_pkg::x_dw-1:0] ex, ax;
        logic [circle_pkg::y_dw-1:0] ey, ay;
        logic [circle_pkg::colour_dw-1:0] ec, ac;
        got_q.delete();
        exp_q.delete();
        if (row_cmd[i] == fill_cmd) begin
            // Column-major raster with y inner and always black
            for (int x = 0; x < circle_pkg::screen_w; x++) begin
                for (int y = 0; y < circle_pkg::screen_h; y++) begin
                    exp_q.push_back({circle_pkg::x_dw'(x), circle_pkg::y_dw'(y),
                                     circle_pkg::colour_dw'(0)});
                end
            end
        end else begin
            model_circle(row_radius[i], row_cx[i], row_cy[i], row_colour[i]);
        end
        bus_cycle(1'b1, circle_pkg::reg_radius, row_radius[i], rd);
        bus_cycle(1'b1, circle_pkg::reg_centre_x, row_cx[i], rd);
        bus_cycle(1'b1, circle_pkg::reg_centre_y, row_cy[i], rd);
        bus_cycle(1'b1, circle_pkg::reg_colour, row_colour[i], rd);
        bus_cycle(1'b1, circle_pkg::reg_ctrl, row_cmd[i], rd);
        // Second start lands while busy and must change nothing
        bus_cycle(1'b1, circle_pkg::reg_ctrl, row_cmd[i], rd);
        rd = 32'h1;
        while (rd[0]) begin
            bus_cycle(1'b0, circle_pkg::reg_status, '0, rd);
        end
        check_word({row_name[i], " status"}, 32'h2, rd);
        check_count(row_name[i], exp_q.size(), got_q.size());
        foreach (exp_q[k]) begin
            {ex, ey, ec} = exp_q[k];
            {ax, ay, ac} = got_q[k];
            check_pixel(row_name[i], k, ex, ey, ec, ax, ay, ac);
        end
    endtask

    initial begin
        logic [circle_pkg::wb_dw-1:0] rd;
        int cx, cy, r, col;
        resetn   = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        rng      = 32'd17;
        // A nonzero colour register must still give black pixels
        add_row("clear_screen", fill_cmd, 0, 0, 0, 7);
        add_row("circle_centre", circle_cmd, 20, 80, 60, 5);
        add_row("circle_edge", circle_cmd, 30, 2, 3, 3);
        add_row("circle_radius_zero", circle_cmd, 0, 50, 40, 6);
        // Centre ranges leave room for radius 40 on every side
        for (int n = 0; n < 4; n++) begin
            rng = xorshift(rng);
            cx  = 40 + int'(rng % 80);
            rng = xorshift(rng);
            cy  = 40 + int'(rng % 40);
            rng = xorshift(rng);
            r   = int'(rng % 41);
            rng = xorshift(rng);
            col = 1 + int'(rng % 7);
            add_row($sformatf("circle_random_%0d", n), circle_cmd, r, cx, cy, col);
        end

        repeat (8) @(posedge clk);
        resetn <= 1'b1;

        // Readback keeps only the field width of each register
        bus_cycle(1'b0, circle_pkg::reg_status, '0, rd);
        check_word("reset_status", 32'h0, rd);
        bus_cycle(1'b1, circle_pkg::reg_radius, 32'hffff_ffa5, rd);
        bus_cycle(1'b0, circle_pkg::reg_radius, '0, rd);
        check_word("radius_readback", 32'h25, rd);
        bus_cycle(1'b1, circle_pkg::reg_centre_x, 32'h0000_019f, rd);
        bus_cycle(1'b0, circle_pkg::reg_centre_x, '0, rd);
        check_word("centre_x_readback", 32'h9f, rd);
        bus_cycle(1'b1, circle_pkg::reg_centre_y, 32'h0000_0177, rd);
        bus_cycle(1'b0, circle_pkg::reg_centre_y, '0, rd);
        check_word("centre_y_readback", 32'h77, rd);
        bus_cycle(1'b1, circle_pkg::reg_colour, 32'h0000_002e, rd);
        bus_cycle(1'b0, circle_pkg::reg_colour, '0, rd);
        check_word("colour_readback", 32'h6, rd);
        // No command bits set, so nothing starts
        bus_cycle(1'b1, circle_pkg::reg_ctrl, 32'hffff_fffc, rd);
        bus_cycle(1'b0, circle_pkg::reg_ctrl, '0, rd);
        check_word("ctrl_readback", 32'h0, rd);
        bus_cycle(1'b1, circle_pkg::reg_status, 32'h3, rd);
        bus_cycle(1'b0, circle_pkg::reg_status, '0, rd);
        check_word("status_write_ignored", 32'h0, rd);
        bus_cycle(1'b1, 3'd6, 32'hffff_ffff, rd);
        bus_cycle(1'b0, 3'd6, '0, rd);
        check_word("unmapped_readback", 32'h0, rd);
        check_count("idle_after_reset", 0, got_q.size());

        for (int i = 0; i < row_name.size(); i++) begin
            run_row(i);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: hdl/circle_top.sv
`timescale 1ns/100ps

module circle_top (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  logic [circle_pkg::wb_aw-1:0]     wb_adr,
    input  logic [circle_pkg::wb_dw-1:0]     wb_dat_w,
    output logic [circle_pkg::wb_dw-1:0]     wb_dat_r,
    output logic                             wb_ack,
    output logic [circle_pkg::x_dw-1:0]      vga_x,
    output logic [circle_pkg::y_dw-1:0]      vga_y,
    output logic [circle_pkg::colour_dw-1:0] vga_colour,
    output logic                             vga_plot
);

    logic [circle_pkg::radius_dw-1:0]     radius;
    logic [circle_pkg::x_dw-1:0]          centre_x;
    logic [circle_pkg::y_dw-1:0]          centre_y;
    logic [circle_pkg::colour_dw-1:0]     colour;
    logic                                 start_fill;
    logic                                 start_circle;
    logic                                 busy;
    logic                                 done;
    logic                                 fill_start;
    logic                                 fill_done;
    logic                                 draw_circle;
    logic                                 load;
    logic                                 step;
    logic [2:0]                           octant_sel;
    logic signed [circle_pkg::off_dw-1:0] offset_x;
    logic signed [circle_pkg::off_dw-1:0] offset_y;

    circle_regs u_regs (
        .clk          (clk),
        .resetn       (resetn),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .busy         (busy),
        .done         (done),
        .radius       (radius),
        .centre_x     (centre_x),
        .centre_y     (centre_y),
        .colour       (colour),
        .start_fill   (start_fill),
        .start_circle (start_circle)
    );

    circle_ctrl u_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .start_fill   (start_fill),
        .start_circle (start_circle),
        .fill_done    (fill_done),
        .offset_x     (offset_x),
        .offset_y     (offset_y),
        .busy         (busy),
        .done         (done),
        .fill_start   (fill_start),
        .draw_circle  (draw_circle),
        .load         (load),
        .step         (step),
        .octant_sel   (octant_sel)
    );

    circle_datapath u_datapath (
        .clk         (clk),
        .resetn      (resetn),
        .radius      (radius),
        .centre_x    (centre_x),
        .centre_y    (centre_y),
        .colour      (colour),
        .fill_start  (fill_start),
        .draw_circle (draw_circle),
        .load        (load),
        .step        (step),
        .octant_sel  (octant_sel),
        .fill_done   (fill_done),
        .offset_x    (offset_x),
        .offset_y    (offset_y),
        .vga_x       (vga_x),
        .vga_y       (vga_y),
        .vga_colour  (vga_colour),
        .vga_plot    (vga_plot)
    );

endmodule

// File: hdl/circle_datapath.sv
`timescale 1ns/100ps

module circle_datapath (
    input  logic                                 clk,
    input  logic                                 resetn,
    input  logic [circle_pkg::radius_dw-1:0]     radius,
    input  logic [circle_pkg::x_dw-1:0]          centre_x,
    input  logic [circle_pkg::y_dw-1:0]          centre_y,
    input  logic [circle_pkg::colour_dw-1:0]     colour,
    input  logic                                 fill_start,
    input  logic                                 draw_circle,
    input  logic                                 load,
    input  logic                                 step,
    input  logic [2:0]                           octant_sel,
    output logic                                 fill_done,
    output logic signed [circle_pkg::off_dw-1:0] offset_x,
    output logic signed [circle_pkg::off_dw-1:0] offset_y,
    output logic [circle_pkg::x_dw-1:0]          vga_x,
    output logic [circle_pkg::y_dw-1:0]          vga_y,
    output logic [circle_pkg::colour_dw-1:0]     vga_colour,
    output logic                                 vga_plot
);

    logic signed [circle_pkg::crit_dw-1:0] crit;
    logic signed [circle_pkg::crit_dw-1:0] crit_next;
    logic signed [circle_pkg::crit_dw-1:0] oy_inc;
    logic signed [circle_pkg::crit_dw-1:0] ox_dec;

    // One extra bit so centre plus offset never wraps
    logic signed [circle_pkg::off_dw:0] cx_s;
    logic signed [circle_pkg::off_dw:0] cy_s;
    logic signed [circle_pkg::off_dw:0] ox_s;
    logic signed [circle_pkg::off_dw:0] oy_s;
    logic signed [circle_pkg::off_dw:0] px;
    logic signed [circle_pkg::off_dw:0] py;

    logic                           on_screen;
    logic [circle_pkg::x_dw-1:0]    circle_x;
    logic [circle_pkg::y_dw-1:0]    circle_y;
    logic [circle_pkg::x_dw-1:0]    fill_x;
    logic [circle_pkg::y_dw-1:0]    fill_y;
    logic                           fill_plot;

    // Midpoint update uses the new offsets
    always_comb begin
        oy_inc = offset_y + 1;
        ox_dec = offset_x - 1;
        if (crit <= 0) begin
            crit_next = crit + 2 * oy_inc + 1;
        end else begin
            crit_next = crit + 2 * (oy_inc - ox_dec) + 1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            offset_x <= '0;
            offset_y <= '0;
            crit     <= '0;
        end else if (load) begin
            offset_x <= radius;
            offset_y <= '0;
            crit     <= 1 - $signed({1'b0, radius});
        end else if (step) begin
            offset_y <= offset_y + 1;
            if (crit > 0) begin
                offset_x <= offset_x - 1;
            end
            crit <= crit_next;
        end
    end

    assign cx_s = centre_x;
    assign cy_s = centre_y;
    assign ox_s = offset_x;
    assign oy_s = offset_y;

    // Octant point, in the order the pixel stream expects
    always_comb begin
        case (octant_sel)
            3'd0: begin px = cx_s + ox_s; py = cy_s + oy_s; end
            3'd1: begin px = cx_s + oy_s; py = cy_s + ox_s; end
            3'd2: begin px = cx_s - oy_s; py = cy_s + ox_s; end
            3'd3: begin px = cx_s - ox_s; py = cy_s + oy_s; end
            3'd4: begin px = cx_s - ox_s; py = cy_s - oy_s; end
            3'd5: begin px = cx_s - oy_s; py = cy_s - ox_s; end
            3'd6: begin px = cx_s + oy_s; py = cy_s - ox_s; end
            default: begin px = cx_s + ox_s; py = cy_s - oy_s; end
        endcase
    end

    // Off-screen candidates become a zero pixel with no plot
    assign on_screen = (px >= 0) && (px < circle_pkg::screen_w)
                       && (py >= 0) && (py < circle_pkg::screen_h);
    assign circle_x  = on_screen ? px[circle_pkg::x_dw-1:0] : '0;
    assign circle_y  = on_screen ? py[circle_pkg::y_dw-1:0] : '0;

    fillscreen u_fillscreen (
        .clk      (clk),
        .resetn   (resetn),
        .start    (fill_start),
        .done     (fill_done),
        .vga_x    (fill_x),
        .vga_y    (fill_y),
        .vga_plot (fill_plot)
    );

    // Clears always paint black
    assign vga_x      = draw_circle ? circle_x : fill_x;
    assign vga_y      = draw_circle ? circle_y : fill_y;
    assign vga_colour = draw_circle ? colour : '0;
    assign vga_plot   = draw_circle ? on_screen : fill_plot;

    assert property (@(posedge clk) disable iff (!resetn)
        vga_plot |-> (vga_x < circle_pkg::screen_w) && (vga_y < circle_pkg::screen_h));

endmodule

// File: hdl/circle_ctrl.sv
`timescale 1ns/100ps

module circle_ctrl (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                start_fill,
    input  logic                                start_circle,
    input  logic                                fill_done,
    input  logic signed [circle_pkg::off_dw-1:0] offset_x,
    input  logic signed [circle_pkg::off_dw-1:0] offset_y,
    output logic                                busy,
    output logic                                done,
    output logic                                fill_start,
    output logic                                draw_circle,
    output logic                                load,
    output logic                                step,
    output logic [2:0]                          octant_sel
);

    logic [2:0] state;
    logic [2:0] state_next;
    logic [2:0] oct_cnt;
    logic       done_r;
    logic       finish;

    // Offsets are new on the first plot cycle after a step
    assign finish = (state == circle_pkg::st_plot) && (offset_y > offset_x);

    always_comb begin
        state_next = state;
        case (state)
            circle_pkg::st_idle: begin
                if (start_fill) begin
                    state_next = circle_pkg::st_clear;
                end else if (start_circle) begin
                    state_next = circle_pkg::st_load;
                end
            end
            circle_pkg::st_clear: begin
                if (fill_done) begin
                    state_next = circle_pkg::st_idle;
                end
            end
            circle_pkg::st_load: state_next = circle_pkg::st_plot;
            circle_pkg::st_plot: begin
                if (finish) begin
                    state_next = circle_pkg::st_idle;
                end else if (oct_cnt == 3'd7) begin
                    state_next = circle_pkg::st_step;
                end
            end
            circle_pkg::st_step: state_next = circle_pkg::st_plot;
            default: state_next = circle_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= circle_pkg::st_idle;
            oct_cnt <= 3'd0;
            done_r  <= 1'b0;
        end else begin
            state <= state_next;
            // Wraps to zero after octant 7, ready for the next step
            if ((state == circle_pkg::st_plot) && !finish) begin
                oct_cnt <= oct_cnt + 3'd1;
            end else begin
                oct_cnt <= 3'd0;
            end
            if ((state == circle_pkg::st_idle) && (start_fill || start_circle)) begin
                done_r <= 1'b0;
            end else if (finish || ((state == circle_pkg::st_clear) && fill_done)) begin
                done_r <= 1'b1;
            end
        end
    end

    // The finishing cycle already counts as idle
    assign busy        = (state != circle_pkg::st_idle) && !finish;
    assign done        = done_r || finish;
    assign fill_start  = (state == circle_pkg::st_idle) && start_fill;
    assign draw_circle = (state == circle_pkg::st_plot) && !finish;
    assign load        = (state == circle_pkg::st_load);
    assign step        = (state == circle_pkg::st_step);
    assign octant_sel  = oct_cnt;

    assert property (@(posedge clk) disable iff (!resetn) !(load && step));

endmodule

// File: hdl/circle_regs.sv
`timescale 1ns/100ps

module circle_regs (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  logic [circle_pkg::wb_aw-1:0]     wb_adr,
    input  logic [circle_pkg::wb_dw-1:0]     wb_dat_w,
    output logic [circle_pkg::wb_dw-1:0]     wb_dat_r,
    output logic                             wb_ack,
    input  logic                             busy,
    input  logic                             done,
    output logic [circle_pkg::radius_dw-1:0] radius,
    output logic [circle_pkg::x_dw-1:0]      centre_x,
    output logic [circle_pkg::y_dw-1:0]      centre_y,
    output logic [circle_pkg::colour_dw-1:0] colour,
    output logic                             start_fill,
    output logic                             start_circle
);

    logic                         access;
    logic                         wr_en;
    logic                         ctrl_wr;
    logic [circle_pkg::wb_dw-1:0] rd_data;

    // A new transfer is taken on this edge
    assign access  = wb_cyc && wb_stb && !wb_ack;
    assign wr_en   = access && wb_we;
    assign ctrl_wr = wr_en && (wb_adr == circle_pkg::reg_ctrl) && !busy;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_ack       <= 1'b0;
            start_fill   <= 1'b0;
            start_circle <= 1'b0;
        end else begin
            wb_ack     <= access;
            start_fill <= ctrl_wr && wb_dat_w[circle_pkg::cmd_fill_bit];
            // Clear wins when both command bits are set
            start_circle <= ctrl_wr && wb_dat_w[circle_pkg::cmd_circle_bit]
                            && !wb_dat_w[circle_pkg::cmd_fill_bit];
        end
    end

    // Drawing parameters
    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (wb_adr)
                circle_pkg::reg_radius:   radius   <= wb_dat_w[circle_pkg::radius_dw-1:0];
                circle_pkg::reg_centre_x: centre_x <= wb_dat_w[circle_pkg::x_dw-1:0];
                circle_pkg::reg_centre_y: centre_y <= wb_dat_w[circle_pkg::y_dw-1:0];
                circle_pkg::reg_colour:   colour   <= wb_dat_w[circle_pkg::colour_dw-1:0];
                default: ;
            endcase
        end
    end

    // Read mux, control and unmapped words read zero
    always_comb begin
        rd_data = '0;
        case (wb_adr)
            circle_pkg::reg_radius:   rd_data[circle_pkg::radius_dw-1:0] = radius;
            circle_pkg::reg_centre_x: rd_data[circle_pkg::x_dw-1:0]      = centre_x;
            circle_pkg::reg_centre_y: rd_data[circle_pkg::y_dw-1:0]      = centre_y;
            circle_pkg::reg_colour:   rd_data[circle_pkg::colour_dw-1:0] = colour;
            circle_pkg::reg_status:   rd_data[1:0]                       = {done, busy};
            default: ;
        endcase
    end

    // Held for the ack cycle
    always_ff @(posedge clk) begin
        if (access) begin
            wb_dat_r <= rd_data;
        end
    end

    // Every ack answers a request seen on the edge before
    assert property (@(posedge clk) disable iff (!resetn)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb));

endmodule

// File: hdl/fillscreen.sv
`timescale 1ns/100ps

module fillscreen (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        start,
    output logic                        done,
    output logic [circle_pkg::x_dw-1:0] vga_x,
    output logic [circle_pkg::y_dw-1:0] vga_y,
    output logic                        vga_plot
);

    logic last_row;
    logic last_col;
    logic active;

    assign last_row = (vga_y == circle_pkg::y_dw'(circle_pkg::screen_h - 1));
    assign last_col = (vga_x == circle_pkg::x_dw'(circle_pkg::screen_w - 1));

    // y counts inside each column
    always_ff @(posedge clk) begin
        if (!resetn) begin
            active <= 1'b0;
            vga_x  <= '0;
            vga_y  <= '0;
        end else if (start) begin
            active <= 1'b1;
            vga_x  <= '0;
            vga_y  <= '0;
        end else if (active) begin
            if (last_row) begin
                vga_y <= '0;
                if (last_col) begin
                    active <= 1'b0;
                    vga_x  <= '0;
                end else begin
                    vga_x <= vga_x + 1'b1;
                end
            end else begin
                vga_y <= vga_y + 1'b1;
            end
        end
    end

    assign vga_plot = active;
    assign done     = active && last_row && last_col;

endmodule

// File: hdl/circle_pkg.sv
package circle_pkg;

    // Frame buffer geometry
    localparam int screen_w = 160;
    localparam int screen_h = 120;

    // Pixel and arithmetic widths
    localparam int x_dw      = 8;
    localparam int y_dw      = 7;
    localparam int radius_dw = 7;
    localparam int off_dw    = 9;
    localparam int crit_dw   = 10;
    localparam int colour_dw = 3;

    // Wishbone bus widths
    localparam int wb_aw = 3;
    localparam int wb_dw = 32;

    // Register map in word addresses
    localparam logic [wb_aw-1:0] reg_ctrl     = 3'd0;
    localparam logic [wb_aw-1:0] reg_radius   = 3'd1;
    localparam logic [wb_aw-1:0] reg_centre_x = 3'd2;
    localparam logic [wb_aw-1:0] reg_centre_y = 3'd3;
    localparam logic [wb_aw-1:0] reg_colour   = 3'd4;
    localparam logic [wb_aw-1:0] reg_status   = 3'd5;

    // Command bits of the control register
    localparam int cmd_fill_bit   = 0;
    localparam int cmd_circle_bit = 1;

    // Controller state encoding
    localparam logic [2:0] st_idle  = 3'd0;
    localparam logic [2:0] st_clear = 3'd1;
    localparam logic [2:0] st_load  = 3'd2;
    localparam logic [2:0] st_plot  = 3'd3;
    localparam logic [2:0] st_step  = 3'd4;

endpackage
